/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_core
RTL_TOP   ?= rv_core
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^sim passed$$" $(LOG) && echo "result: pass" || \
	  (echo "result: fail, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/rv_alu.sv */
module rv_alu
  import rv_core_pkg::*;
(
  input  alu_op_t i_op,
  input  logic    i_alt,
  input  word_t   i_a,
  input  word_t   i_b,
  output word_t   o_y
);

  logic [4:0] shamt;

  assign shamt = i_b[4:0];

  always_comb begin
    case (i_op)
      alu_add: begin
        if (i_alt) begin
          o_y = i_a - i_b;
        end else begin
          o_y = i_a + i_b;
        end
      end
      alu_sll:  o_y = i_a << shamt;
      alu_slt:  o_y = {31'd0, $signed(i_a) < $signed(i_b)};
      alu_sltu: o_y = {31'd0, i_a < i_b};
      alu_xor:  o_y = i_a ^ i_b;
      alu_srl: begin
        // arithmetic shift keeps the sign
        if (i_alt) begin
          o_y = $unsigned($signed(i_a) >>> shamt);
        end else begin
          o_y = i_a >> shamt;
        end
      end
      alu_or:   o_y = i_a | i_b;
      alu_and:  o_y = i_a & i_b;
      default:  o_y = i_a + i_b;
    endcase
  end

endmodule

/* hdl/rv_core.sv */
module rv_core
  import rv_core_pkg::*;
(
  input  logic    clk,
  input  logic    nrst,
  output word_t   o_imem_addr,
  input  word_t   i_imem_data,
  input  logic    i_halt_req,
  input  logic    i_resume_req,
  input  word_t   i_resume_pc,
  output logic    o_halt,
  output commit_t o_commit
);

  logic       fetch_valid;
  word_t      fetch_pc;
  logic       stall;
  logic       redirect;
  word_t      target;
  reg_addr_t  rs1_addr;
  reg_addr_t  rs2_addr;
  word_t      rs1_data;
  word_t      rs2_data;
  logic       rs1_pending;
  logic       rs2_pending;
  logic       rd_pending;
  logic       claim;
  reg_addr_t  claim_addr;
  logic       release_rd;
  reg_addr_t  release_addr;
  dec_stage_t dec;

  rv_fetch i_fetch (
    .clk           (clk),
    .nrst          (nrst),
    .i_halt_req    (i_halt_req),
    .i_resume_req  (i_resume_req),
    .i_resume_pc   (i_resume_pc),
    .i_stall       (stall),
    .i_redirect    (redirect),
    .i_target      (target),
    .o_imem_addr   (o_imem_addr),
    .o_halt        (o_halt),
    .o_fetch_valid (fetch_valid),
    .o_fetch_pc    (fetch_pc)
  );

  rv_decode i_decode (
    .clk (clk), .nrst (nrst),
    .i_fetch_valid (fetch_valid), .i_fetch_pc (fetch_pc), .i_inst (i_imem_data),
    .i_flush (redirect), .o_rs1_addr (rs1_addr), .o_rs2_addr (rs2_addr),
    .i_rs1_data (rs1_data), .i_rs2_data (rs2_data), .i_rs1_pending (rs1_pending),
    .i_rs2_pending (rs2_pending), .i_rd_pending (rd_pending), .o_claim (claim),
    .o_claim_addr (claim_addr), .o_stall (stall), .o_dec (dec)
  );

  rv_regfile i_regfile (
    .clk (clk), .nrst (nrst), .i_rs1_addr (rs1_addr), .i_rs2_addr (rs2_addr),
    .o_rs1_data (rs1_data), .o_rs2_data (rs2_data), .o_rs1_pending (rs1_pending),
    .o_rs2_pending (rs2_pending), .o_rd_pending (rd_pending), .i_rd_addr (claim_addr),
    .i_claim (claim), .i_claim_addr (claim_addr), .i_release (release_rd),
    .i_release_addr (release_addr), .i_wr (o_commit)
  );

  rv_execute i_execute (
    .clk (clk), .nrst (nrst), .i_dec (dec), .o_redirect (redirect), .o_target (target),
    .o_release (release_rd), .o_release_addr (release_addr), .o_commit (o_commit)
  );

endmodule

/* hdl/rv_core_pkg.sv */
package rv_core_pkg;

  // base widths
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // major opcodes, inst[6:2]
  localparam logic [4:0] opcode_op     = 5'b01100;
  localparam logic [4:0] opcode_op_imm = 5'b00100;
  localparam logic [4:0] opcode_lui    = 5'b01101;
  localparam logic [4:0] opcode_auipc  = 5'b00101;
  localparam logic [4:0] opcode_jal    = 5'b11011;
  localparam logic [4:0] opcode_jalr   = 5'b11001;
  localparam logic [4:0] opcode_branch = 5'b11000;
  // stores only need their immediate format, they retire as no-ops
  localparam logic [4:0] opcode_store  = 5'b01000;

  // branch conditions
  localparam logic [2:0] funct3_beq  = 3'b000;
  localparam logic [2:0] funct3_bne  = 3'b001;
  localparam logic [2:0] funct3_blt  = 3'b100;
  localparam logic [2:0] funct3_bge  = 3'b101;
  localparam logic [2:0] funct3_bltu = 3'b110;
  localparam logic [2:0] funct3_bgeu = 3'b111;

  // alu shift right, srl or sra by inst[30]
  localparam logic [2:0] funct3_sr   = 3'b101;

  // encoded like the OP/OP_IMM funct3
  typedef enum logic [2:0] {
    alu_add  = 3'b000,
    alu_sll  = 3'b001,
    alu_slt  = 3'b010,
    alu_sltu = 3'b011,
    alu_xor  = 3'b100,
    alu_srl  = 3'b101,
    alu_or   = 3'b110,
    alu_and  = 3'b111
  } alu_op_t;

  // decode to execute
  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     inst;
    word_t     imm;
    word_t     rs1_data;
    word_t     rs2_data;
    reg_addr_t rd_addr;
    logic      rd_wb;
    alu_op_t   alu_op;
    // sub / sra
    logic      alu_alt;
    // operand 1 is pc (auipc)
    logic      src1_pc;
    // operand 1 is zero (lui)
    logic      src1_zero;
    // operand 2 is the immediate
    logic      src2_imm;
  } dec_stage_t;

  // retired instruction, also drives the register file write
  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     inst;
    reg_addr_t rd_addr;
    logic      rd_wb;
    word_t     rd_data;
  } commit_t;

endpackage

/* hdl/rv_decode.sv */
module rv_decode
  import rv_core_pkg::*;
(
  input  logic       clk,
  input  logic       nrst,
  input  logic       i_fetch_valid,
  input  word_t      i_fetch_pc,
  input  word_t      i_inst,
  input  logic       i_flush,
  output reg_addr_t  o_rs1_addr,
  output reg_addr_t  o_rs2_addr,
  input  word_t      i_rs1_data,
  input  word_t      i_rs2_data,
  input  logic       i_rs1_pending,
  input  logic       i_rs2_pending,
  input  logic       i_rd_pending,
  output logic       o_claim,
  output reg_addr_t  o_claim_addr,
  output logic       o_stall,
  output dec_stage_t o_dec
);

  logic [4:0] opcode;
  logic [2:0] funct3;
  dec_stage_t dec_d;
  dec_stage_t dec_q;

  assign opcode = i_inst[6:2];
  assign funct3 = i_inst[14:12];

  assign o_rs1_addr   = i_inst[19:15];
  assign o_rs2_addr   = i_inst[24:20];
  assign o_claim_addr = i_inst[11:7];

  always_comb begin
    dec_d.pc       = i_fetch_pc;
    dec_d.inst     = i_inst;
    dec_d.rs1_data = i_rs1_data;
    dec_d.rs2_data = i_rs2_data;
    dec_d.rd_addr  = i_inst[11:7];

    case (opcode)
      opcode_store: dec_d.imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
      opcode_lui, opcode_auipc: dec_d.imm = {i_inst[31:12], 12'h000};
      opcode_jal: dec_d.imm = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20],
                               i_inst[30:21], 1'b0};
      opcode_branch: dec_d.imm = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25],
                                  i_inst[11:8], 1'b0};
      default: dec_d.imm = {{20{i_inst[31]}}, i_inst[31:20]};
    endcase

    dec_d.alu_op  = alu_add;
    dec_d.alu_alt = 1'b0;
    if (opcode == opcode_op) begin
      dec_d.alu_op  = alu_op_t'(funct3);
      dec_d.alu_alt = i_inst[30];
    end else if (opcode == opcode_op_imm) begin
      dec_d.alu_op  = alu_op_t'(funct3);
      // bit 30 is part of the immediate except for shifts right
      dec_d.alu_alt = (funct3 == funct3_sr) & i_inst[30];
    end else if (opcode == opcode_branch) begin
      case (funct3)
        funct3_beq, funct3_bne:   dec_d.alu_op = alu_xor;
        funct3_blt, funct3_bge:   dec_d.alu_op = alu_slt;
        funct3_bltu, funct3_bgeu: dec_d.alu_op = alu_sltu;
        default:                  dec_d.alu_op = alu_add;
      endcase
    end

    dec_d.src1_zero = (opcode == opcode_lui);
    dec_d.src1_pc   = (opcode == opcode_auipc);
    dec_d.src2_imm  = (opcode == opcode_op_imm) || (opcode == opcode_lui) ||
                      (opcode == opcode_auipc) || (opcode == opcode_jal) ||
                      (opcode == opcode_jalr);

    // fence and unknown opcodes never write
    dec_d.rd_wb = (dec_d.rd_addr != '0) &&
                  ((opcode == opcode_op) || (opcode == opcode_op_imm) ||
                   (opcode == opcode_lui) || (opcode == opcode_auipc) ||
                   (opcode == opcode_jal) || (opcode == opcode_jalr));

    dec_d.valid = i_fetch_valid & ~o_stall & ~i_flush;
  end

  // raw on either source, waw on the destination
  assign o_stall = i_fetch_valid &
                   (i_rs1_pending | i_rs2_pending | (dec_d.rd_wb & i_rd_pending));
  assign o_claim = dec_d.valid & dec_d.rd_wb;

  always_ff @(posedge clk) begin
    dec_q <= dec_d;
    if (!nrst) begin
      dec_q.valid <= 1'b0;
    end
  end

  assign o_dec = dec_q;

endmodule

/* hdl/rv_execute.sv */
module rv_execute
  import rv_core_pkg::*;
(
  input  logic       clk,
  input  logic       nrst,
  input  dec_stage_t i_dec,
  output logic       o_redirect,
  output word_t      o_target,
  output logic       o_release,
  output reg_addr_t  o_release_addr,
  output commit_t    o_commit
);

  dec_stage_t exec_q;
  commit_t    commit_q;
  logic [4:0] opcode;
  logic [2:0] funct3;
  logic       is_jal;
  logic       is_jalr;
  logic       taken;
  word_t      alu_a;
  word_t      alu_b;
  word_t      alu_y;

  assign opcode  = exec_q.inst[6:2];
  assign funct3  = exec_q.inst[14:12];
  assign is_jal  = (opcode == opcode_jal);
  assign is_jalr = (opcode == opcode_jalr);

  assign alu_a = exec_q.src1_zero ? '0 : (exec_q.src1_pc ? exec_q.pc : exec_q.rs1_data);
  assign alu_b = exec_q.src2_imm ? exec_q.imm : exec_q.rs2_data;

  rv_alu i_alu (
    .i_op  (exec_q.alu_op),
    .i_alt (exec_q.alu_alt),
    .i_a   (alu_a),
    .i_b   (alu_b),
    .o_y   (alu_y)
  );

  // beq, bge and bgeu take on a zero result
  always_comb begin
    case (funct3)
      funct3_beq, funct3_bge, funct3_bgeu: taken = (alu_y == '0);
      funct3_bne, funct3_blt, funct3_bltu: taken = (alu_y != '0);
      // funct3 010 and 011 are no branches
      default:                             taken = 1'b0;
    endcase
  end

  assign o_redirect = exec_q.valid & (is_jal | is_jalr | ((opcode == opcode_branch) & taken));
  assign o_target   = is_jalr ? ((exec_q.rs1_data + exec_q.imm) & ~32'd1) :
                      (exec_q.pc + exec_q.imm);

  // the decoded instruction behind a taken redirect gives back its claim
  assign o_release      = o_redirect & i_dec.valid & i_dec.rd_wb;
  assign o_release_addr = i_dec.rd_addr;

  always_ff @(posedge clk) begin
    exec_q         <= i_dec;
    exec_q.valid   <= i_dec.valid & ~o_redirect;
    commit_q.valid   <= exec_q.valid;
    commit_q.pc      <= exec_q.pc;
    commit_q.inst    <= exec_q.inst;
    commit_q.rd_addr <= exec_q.rd_addr;
    commit_q.rd_wb   <= exec_q.rd_wb;
    commit_q.rd_data <= (is_jal || is_jalr) ? exec_q.pc + 32'd4 : alu_y;
    if (!nrst) begin
      exec_q.valid   <= 1'b0;
      commit_q.valid <= 1'b0;
    end
  end

  assign o_commit = commit_q;

endmodule

/* hdl/rv_fetch.sv */
module rv_fetch
  import rv_core_pkg::*;
(
  input  logic  clk,
  input  logic  nrst,
  input  logic  i_halt_req,
  input  logic  i_resume_req,
  input  word_t i_resume_pc,
  input  logic  i_stall,
  input  logic  i_redirect,
  input  word_t i_target,
  output word_t o_imem_addr,
  output logic  o_halt,
  output logic  o_fetch_valid,
  output word_t o_fetch_pc
);

  logic  running_q;
  logic  fetch_valid_q;
  word_t fetch_pc_q;
  word_t next_addr;
  logic  next_valid;

  assign o_halt = ~running_q;

  // address goes out this cycle, the word comes back on the next
  always_comb begin
    if (~running_q && i_resume_req) begin
      next_addr  = i_resume_pc;
      next_valid = 1'b1;
    end else if (i_redirect) begin
      // the word arriving now is dropped by the decode flush
      next_addr  = i_target;
      next_valid = running_q;
    end else if (running_q && ~i_stall) begin
      next_addr  = fetch_pc_q + 32'd4;
      next_valid = 1'b1;
    end else begin
      // a stalled word is fetched again, even while halting
      next_addr  = fetch_pc_q;
      next_valid = fetch_valid_q & i_stall;
    end
  end

  assign o_imem_addr = next_addr;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      running_q     <= 1'b0;
      fetch_valid_q <= 1'b0;
      fetch_pc_q    <= '0;
    end else begin
      if (~running_q && i_resume_req) begin
        running_q <= 1'b1;
      end else if (i_halt_req) begin
        running_q <= 1'b0;
      end
      fetch_valid_q <= next_valid;
      fetch_pc_q    <= next_addr;
    end
  end

  assign o_fetch_valid = fetch_valid_q;
  assign o_fetch_pc    = fetch_pc_q;

endmodule

/* hdl/rv_regfile.sv */
module rv_regfile
  import rv_core_pkg::*;
(
  input  logic      clk,
  input  logic      nrst,
  input  reg_addr_t i_rs1_addr,
  input  reg_addr_t i_rs2_addr,
  output word_t     o_rs1_data,
  output word_t     o_rs2_data,
  output logic      o_rs1_pending,
  output logic      o_rs2_pending,
  output logic      o_rd_pending,
  input  reg_addr_t i_rd_addr,
  input  logic      i_claim,
  input  reg_addr_t i_claim_addr,
  input  logic      i_release,
  input  reg_addr_t i_release_addr,
  input  commit_t   i_wr
);

  word_t       regs [32];
  logic [31:0] pending;
  logic        wr_en;

  assign wr_en = i_wr.valid & i_wr.rd_wb & (i_wr.rd_addr != '0);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      regs[i_wr.rd_addr] <= i_wr.rd_data;
    end
  end

  // a claim in the same cycle as a clear wins
  always_ff @(posedge clk) begin
    if (!nrst) begin
      pending <= '0;
    end else begin
      if (wr_en) begin
        pending[i_wr.rd_addr] <= 1'b0;
      end
      if (i_release) begin
        pending[i_release_addr] <= 1'b0;
      end
      if (i_claim && i_claim_addr != '0) begin
        pending[i_claim_addr] <= 1'b1;
      end
    end
  end

  // write-through, so a committing value is usable in the same cycle
  assign o_rs1_data = (i_rs1_addr == '0) ? '0 :
                      (wr_en && i_wr.rd_addr == i_rs1_addr) ? i_wr.rd_data : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 :
                      (wr_en && i_wr.rd_addr == i_rs2_addr) ? i_wr.rd_data : regs[i_rs2_addr];

  assign o_rs1_pending = pending[i_rs1_addr] & ~(wr_en && i_wr.rd_addr == i_rs1_addr);
  assign o_rs2_pending = pending[i_rs2_addr] & ~(wr_en && i_wr.rd_addr == i_rs2_addr);
  assign o_rd_pending  = pending[i_rd_addr] & ~(wr_en && i_wr.rd_addr == i_rd_addr);

endmodule

/* rv_core.f */
hdl/rv_core_pkg.sv
hdl/rv_alu.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_core.sv
tests/rv_core_props.sv
tests/tb_rv_core.sv

/* tests/rv_core_props.sv */
module rv_core_props
  import rv_core_pkg::*;
(
  input logic    clk,
  input logic    nrst,
  input logic    o_halt,
  input commit_t o_commit
);
  timeunit 1ns;
  timeprecision 100ps;

  logic in_reset_q = 1'b0;

  always_ff @(posedge clk) begin
    in_reset_q <= ~nrst;
  end

  // one reset edge has passed, so the commit register is cleared
  a_no_commit_in_reset: assert property (@(posedge clk) (~nrst && in_reset_q) |-> ~o_commit.valid)
    else $error("commit valid while reset is held");

  a_halted_after_reset: assert property (@(posedge clk) $rose(nrst) |-> o_halt)
    else $error("core not halted right after reset");

  a_commit_pc_known: assert property (@(posedge clk) disable iff (~nrst)
    o_commit.valid |-> !$isunknown(o_commit.pc))
    else $error("commit pc unknown while commit is valid");

endmodule

bind rv_core rv_core_props i_props (
  .clk      (clk),
  .nrst     (nrst),
  .o_halt   (o_halt),
  .o_commit (o_commit)
);

/* tests/tb_rv_core.sv */
module tb_rv_core
  import rv_core_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  logic    clk = 1'b0;
  logic    nrst, i_halt_req, i_resume_req, o_halt;
  word_t   i_resume_pc, o_imem_addr, i_imem_data;
  commit_t o_commit, exp_c;
  word_t   mem [4096];
  word_t   ref_regs [32];
  word_t   loop_pc [5];
  word_t   iss_pc, iss_next, last_pc;
  int      lp, n_instrs, n_commits, n_checks, errors, seed, r, f, imm, e0, c1;

  always #5 clk = ~clk;

  rv_core i_dut (.*);

  // synchronous read with the word one cycle after its address
  always @(posedge clk) begin
    i_imem_data <= mem[o_imem_addr[13:2]];
  end

  function automatic word_t rtype(input int f3, alt, rd, rs1, rs2);
    return {1'b0, 1'(alt), 5'd0, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'h33};
  endfunction
  function automatic word_t itype(input int opc, f3, rd, rs1, imm);
    return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'(opc)};
  endfunction
  function automatic word_t utype(input int opc, rd, imm);
    return {20'(imm), 5'(rd), 7'(opc)};
  endfunction
  function automatic word_t jtype(input int rd, input word_t o);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'h6f};
  endfunction
  function automatic word_t btype(input int f3, rs1, rs2, input word_t o);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], 7'h63};
  endfunction

  task automatic put(input word_t w);
    mem[lp] = w;
    lp++;
    n_instrs++;
  endtask

  // each program ends in a jump to itself
  task automatic finish_prog(input int idx);
    loop_pc[idx] = word_t'(lp * 4);
    put(jtype(0, 0));
  endtask

  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a, b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // one instruction of the reference model
  function automatic commit_t iss_step(input word_t pc, output word_t npc);
    commit_t    c;
    word_t      inst, a, b, immi, res;
    logic [2:0] f3;
    logic       take;
    inst = mem[pc[13:2]];
    f3   = inst[14:12];
    a    = ref_regs[inst[19:15]];
    b    = ref_regs[inst[24:20]];
    immi = {{20{inst[31]}}, inst[31:20]};
    c = '{valid: 1'b1, pc: pc, inst: inst, rd_addr: inst[11:7], rd_wb: 1'b0, rd_data: '0};
    npc  = pc + 32'd4;
    res  = '0;
    take = 1'b0;
    case (inst[6:0])
      7'h33: {c.rd_wb, res} = {1'b1, alu_ref(f3, inst[30], a, b)};
      7'h13: {c.rd_wb, res} = {1'b1, alu_ref(f3, (f3 == 3'd5) & inst[30], a, immi)};
      7'h37: {c.rd_wb, res} = {1'b1, inst[31:12], 12'h000};
      7'h17: {c.rd_wb, res} = {1'b1, pc + {inst[31:12], 12'h000}};
      7'h6f: begin
        {c.rd_wb, res} = {1'b1, pc + 32'd4};
        npc = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      7'h67: begin
        {c.rd_wb, res} = {1'b1, pc + 32'd4};
        npc = (a + immi) & ~32'd1;
      end
      7'h63: begin
        case (f3)
          3'd0: take = (a == b);
          3'd1: take = (a != b);
          3'd4: take = ($signed(a) < $signed(b));
          3'd5: take = ($signed(a) >= $signed(b));
          3'd6: take = (a < b);
          3'd7: take = (a >= b);
          default: take = 1'b0;
        endcase
        if (take) begin
          npc = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        end
      end
      default: ;
    endcase
    c.rd_wb   = c.rd_wb & (inst[11:7] != 5'd0);
    c.rd_data = res;
    return c;
  endfunction

  task automatic check_val(input string name, input word_t exp, input word_t act);
    n_checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  always @(negedge clk) begin
    if (nrst && o_commit.valid) begin
      exp_c = iss_step(iss_pc, iss_next);
      check_val("o_commit.pc", exp_c.pc, o_commit.pc);
      check_val("o_commit.inst", exp_c.inst, o_commit.inst);
      check_val("o_commit.rd_wb", 32'(exp_c.rd_wb), 32'(o_commit.rd_wb));
      if (exp_c.rd_wb) begin
        check_val("o_commit.rd_addr", 32'(exp_c.rd_addr), 32'(o_commit.rd_addr));
        check_val("o_commit.rd_data", exp_c.rd_data, o_commit.rd_data);
        ref_regs[exp_c.rd_addr] = exp_c.rd_data;
      end
      iss_pc  = iss_next;
      last_pc = o_commit.pc;
      n_commits++;
    end
  end

  task automatic start_at(input word_t pc);
    @(negedge clk);
    iss_pc       = pc;
    last_pc      = '1;
    i_resume_pc  = pc;
    i_resume_req = 1'b1;
    @(negedge clk);
    i_resume_req = 1'b0;
  endtask

  // last_pc changes on the falling edge, so it is read on the rising one
  task automatic wait_pc(input word_t pc);
    int k;
    k = 0;
    while (last_pc !== pc && k < 5000) begin
      @(posedge clk);
      k++;
    end
    if (last_pc !== pc) begin
      errors++;
      $display("program never reached pc %h", pc);
    end
  endtask

  task automatic halt_drain();
    int k;
    k = 0;
    @(negedge clk);
    i_halt_req = 1'b1;
    @(negedge clk);
    i_halt_req = 1'b0;
    while (!o_halt && k < 20) begin
      @(negedge clk);
      k++;
    end
    if (!o_halt) begin
      errors++;
      $display("core did not halt after a halt request");
    end
    repeat (8) @(negedge clk);
  endtask

  task automatic test_done(input string name, input int errs_before);
    $display("test %-12s %s", name, (errors == errs_before) ? "ok" : "mismatch");
  endtask

  task automatic run_prog(input string name, input word_t start, input word_t end_pc);
    int e;
    e = errors;
    start_at(start);
    wait_pc(end_pc);
    halt_drain();
    test_done(name, e);
  endtask

  initial begin
    nrst = 1'b0;
    i_halt_req = 1'b0;
    i_resume_req = 1'b0;
    i_resume_pc = '0;
    i_imem_data <= '0;
    seed = 37553;
    {n_instrs, n_commits, n_checks, errors} = '0;
    iss_pc = '0;
    last_pc = '1;
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    // fill with op_imm to x0 that carry the word index
    for (int i = 0; i < 4096; i++) mem[i] = {8'h00, 12'(i), 12'h013};

    // straight line at 0x100
    lp = 64;
    for (int i = 1; i < 32; i++) put(itype('h13, 0, i, 0, i * 97 - 1500));
    put(utype('h37, 5, 'habcde));
    put(utype('h17, 6, 'h12345));
    for (int i = 0; i < 8; i++) begin
      put(rtype(i, 0, 12 + i, i + 1, 30 - i));
      put(itype('h13, i, 20 + i, i + 3, (i == 1 || i == 5) ? i + 7 : i * 111 - 300));
    end
    put(rtype(0, 1, 3, 4, 5));
    put(rtype(5, 1, 4, 7, 8));
    put(itype('h13, 5, 9, 6, 'h409));
    finish_prog(0);

    // dependency chains at 0x400
    lp = 256;
    put(itype('h13, 0, 1, 0, 1));
    repeat (3) put(itype('h13, 0, 1, 1, 1));
    put(rtype(0, 0, 2, 1, 1));
    put(rtype(0, 1, 3, 2, 1));
    put(rtype(0, 0, 0, 3, 3));
    put(rtype(0, 0, 4, 0, 3));
    put(rtype(1, 0, 5, 4, 1));
    put(rtype(0, 1, 7, 0, 5));
    put(rtype(5, 1, 7, 7, 1));
    put(utype('h37, 8, 'h80000));
    put(itype('h13, 0, 8, 8, -1));
    put(rtype(4, 0, 9, 8, 8));
    put(rtype(2, 0, 10, 7, 1));
    put(rtype(3, 0, 10, 7, 1));
    finish_prog(1);

    // all six branch kinds on three operand pairs plus jal and jalr at 0x600
    lp = 384;
    put(itype('h13, 0, 1, 0, 5));
    put(itype('h13, 0, 2, 0, -3));
    for (int i = 0; i < 6; i++) begin
      for (int j = 0; j < 3; j++) begin
        put(btype((i < 2) ? i : i + 2, (j == 1) ? 2 : 1, (j == 0) ? 2 : 1, 8));
        put(itype('h13, 0, 7, 7, 1));
      end
    end
    put(jtype(8, 8));
    put(itype('h13, 0, 7, 7, 100));
    put(utype('h17, 9, 0));
    put(itype('h67, 0, 10, 9, 12));
    put(itype('h13, 0, 7, 7, 100));
    put(rtype(0, 0, 11, 8, 10));
    finish_prog(2);

    // long straight program for halt and resume at 0x800
    lp = 512;
    for (int i = 0; i < 48; i++) begin
      put((i % 3 == 2) ? rtype(0, 0, 12, 12, 11) : itype('h13, 0, 11, 11, 3));
    end
    finish_prog(3);

    // random alu ops and short forward branches at 0xc00
    lp = 768;
    for (int i = 0; i < 200; i++) begin
      r = $random(seed);
      f = (r >> 2) & 7;
      imm = (f == 1 || f == 5) ? (((f == 5 && r[25]) ? 'h400 : 0) | ((r >> 20) & 31))
                               : r >>> 20;
      case (r & 3)
        0: put(rtype(f, (f == 0 || f == 5) && r[20], (r >> 5) & 31, (r >> 10) & 31,
                     (r >> 15) & 31));
        3: put(btype((f == 2 || f == 3) ? f - 2 : f, (r >> 10) & 31, (r >> 15) & 31,
                     r[20] ? 12 : 8));
        default: put(itype('h13, f, (r >> 5) & 31, (r >> 10) & 31, imm));
      endcase
    end
    repeat (2) put(itype('h13, 0, 0, 0, 0));
    finish_prog(4);

    repeat (4) @(negedge clk);
    nrst = 1'b1;

    e0 = errors;
    repeat (20) begin
      @(negedge clk);
      check_val("o_halt", 32'd1, 32'(o_halt));
      check_val("o_commit.valid", 32'd0, 32'(o_commit.valid));
    end
    test_done("reset idle", e0);

    run_prog("straight", 32'h100, loop_pc[0]);
    run_prog("dependent", 32'h400, loop_pc[1]);
    run_prog("branches", 32'h600, loop_pc[2]);

    e0 = errors;
    start_at(32'h800);
    wait_pc(32'h828);
    halt_drain();
    c1 = n_commits;
    repeat (20) @(negedge clk);
    check_val("commits after halt", 32'(c1), 32'(n_commits));
    check_val("o_halt", 32'd1, 32'(o_halt));
    start_at(32'h880);
    wait_pc(loop_pc[3]);
    halt_drain();
    test_done("halt resume", e0);

    run_prog("random", 32'hc00, loop_pc[4]);

    $display("tests done: %0d commits, %0d checks, %0d errors", n_commits, n_checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // budget scales with the number of program instructions
  initial begin
    #1;
    repeat (200 * n_instrs + 1000) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", 200 * n_instrs + 1000);
    $display("sim failed");
    $finish;
  end

endmodule
